//--- load_queue.sv
// Load queue. Holds dispatched loads until their offset arrives, offers
// the lowest ready load that is older than the store queue head, collects
// fill data and broadcasts one finished load per cycle on the result port.

`timescale 1ns/1ps
`default_nettype none

module load_queue #(
	parameter int LQ_SIZE = 8,
	localparam int IDX_W = $clog2(LQ_SIZE)
) (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            mispredict,
	lsq_dispatch_if.receiver               dispatch,
	input  wire                            cdb_valid,
	input  wire lsq_types_pkg::tag_t       cdb_tag,
	input  wire lsq_types_pkg::data_t      cdb_data,
	input  wire lsq_types_pkg::rob_idx_t   rob_head,
	input  wire lsq_types_pkg::rob_idx_t   sq_head_rob_idx,
	input  wire                            sq_empty,
	load_req_if.queue                      load_req,
	input  wire                            fill_valid,
	input  wire [IDX_W-1:0]                fill_index,
	input  wire lsq_types_pkg::data_t      mem_data_in,
	output logic                           result_valid,
	output lsq_types_pkg::tag_t            result_tag,
	output lsq_types_pkg::data_t           result_data,
	output lsq_types_pkg::rob_idx_t        result_rob_idx,
	output logic                           lq_full
);

	logic [LQ_SIZE-1:0] valid;
	logic [LQ_SIZE-1:0] requested;	// Sent to memory, waiting for fill
	logic [LQ_SIZE-1:0] done;		// Data back, waiting for broadcast
	logic [LQ_SIZE-1:0] offset_ready;
	lsq_types_pkg::data_t base [LQ_SIZE];
	lsq_types_pkg::data_t offset [LQ_SIZE];
	lsq_types_pkg::data_t data [LQ_SIZE];
	lsq_types_pkg::rob_idx_t rob_idx [LQ_SIZE];
	lsq_types_pkg::tag_t dest_tag [LQ_SIZE];

	logic [IDX_W-1:0] alloc_index;
	logic [IDX_W-1:0] out_index;
	lsq_types_pkg::rob_idx_t store_age;
	logic dispatch_load;
	logic dispatch_hit;

	assign lq_full = &valid;
	assign dispatch_load = dispatch.valid && !dispatch.is_store && !lq_full;
	assign dispatch_hit = !dispatch.offset_ready && cdb_valid &&
		cdb_tag == lsq_types_pkg::tag_t'(dispatch.offset);
	assign store_age = sq_head_rob_idx - rob_head;

	always_comb begin
		alloc_index = '0;
		for (int i = LQ_SIZE - 1; i >= 0; i--)
			if (!valid[i])
				alloc_index = IDX_W'(i);	// Lowest free entry wins
	end

	////////////////////
	// Issue candidate
	////////////////////
	always_comb begin
		load_req.valid = 1'b0;
		load_req.index = '0;
		for (int i = LQ_SIZE - 1; i >= 0; i--) begin
			if (valid[i] && offset_ready[i] && !requested[i] && (sq_empty ||
					lsq_types_pkg::rob_idx_t'(rob_idx[i] - rob_head) < store_age)) begin
				load_req.valid = 1'b1;
				load_req.index = IDX_W'(i);
			end
		end
	end

	assign load_req.address = base[load_req.index] + offset[load_req.index];

	////////////////////
	// Result broadcast
	////////////////////
	always_comb begin
		result_valid = 1'b0;
		out_index = '0;
		for (int i = LQ_SIZE - 1; i >= 0; i--) begin
			if (done[i]) begin
				result_valid = 1'b1;
				out_index = IDX_W'(i);
			end
		end
	end

	assign result_tag = dest_tag[out_index];
	assign result_data = data[out_index];
	assign result_rob_idx = rob_idx[out_index];

	// Entry state, a flush empties the whole queue
	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			valid <= '0;
			requested <= '0;
			done <= '0;
		end else begin
			for (int i = 0; i < LQ_SIZE; i++) begin
				if (load_req.grant[i])
					requested[i] <= 1'b1;
				if (fill_valid && fill_index == IDX_W'(i))
					done[i] <= 1'b1;
				if (result_valid && out_index == IDX_W'(i)) begin
					valid[i] <= 1'b0;
					requested[i] <= 1'b0;
					done[i] <= 1'b0;
				end
				if (dispatch_load && alloc_index == IDX_W'(i)) begin
					valid[i] <= 1'b1;
					requested[i] <= 1'b0;
					done[i] <= 1'b0;
				end
			end
		end
	end

	// Operands and load data
	always_ff @(posedge clock) begin
		for (int i = 0; i < LQ_SIZE; i++) begin
			if (dispatch_load && alloc_index == IDX_W'(i)) begin
				base[i] <= dispatch.base;
				offset[i] <= dispatch_hit ? cdb_data : dispatch.offset;
				offset_ready[i] <= dispatch.offset_ready || dispatch_hit;
				rob_idx[i] <= dispatch.rob_idx;
				dest_tag[i] <= dispatch.dest_tag;
			end else if (!offset_ready[i] && cdb_valid &&
					cdb_tag == lsq_types_pkg::tag_t'(offset[i])) begin
				offset[i] <= cdb_data;	// Late offset from the result bus
				offset_ready[i] <= 1'b1;
			end
			if (fill_valid && fill_index == IDX_W'(i))
				data[i] <= mem_data_in;
		end
	end

endmodule

`default_nettype wire

//--- lsq.f
lsq_types_pkg.sv
mem_bus_pkg.sv
lsq_if.sv
load_queue.sv
store_queue.sv
mem_request_arbiter.sv
mem_tag_table.sv
lsq.sv
lsq_tb_mem.sv
lsq_tb.sv

//--- lsq.sv
// Load/store queue top level with plain ports.
// Connects dispatch, the result bus and the data memory port to the load
// queue, store queue, request arbiter and memory tag table.

`timescale 1ns/1ps
`default_nettype none

module lsq #(
	parameter int LQ_SIZE = 8,
	parameter int SQ_SIZE = 8
) (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            dispatch_valid,
	input  wire                            dispatch_is_store,
	input  wire lsq_types_pkg::data_t      dispatch_base,
	input  wire lsq_types_pkg::data_t      dispatch_offset,
	input  wire                            dispatch_offset_ready,
	input  wire lsq_types_pkg::data_t      dispatch_store_data,
	input  wire                            dispatch_store_data_ready,
	input  wire lsq_types_pkg::rob_idx_t   dispatch_rob_idx,
	input  wire lsq_types_pkg::tag_t       dispatch_dest_tag,
	input  wire                            cdb_valid,
	input  wire lsq_types_pkg::tag_t       cdb_tag,
	input  wire lsq_types_pkg::data_t      cdb_data,
	input  wire lsq_types_pkg::rob_idx_t   rob_head,
	input  wire                            mispredict,
	output mem_bus_pkg::bus_command_e      mem_command,
	output lsq_types_pkg::data_t           mem_address,
	output lsq_types_pkg::data_t           mem_data,
	input  wire mem_bus_pkg::mem_tag_t     mem_response,
	input  wire mem_bus_pkg::mem_tag_t     mem_tag,
	input  wire lsq_types_pkg::data_t      mem_data_in,
	output logic                           result_valid,
	output lsq_types_pkg::tag_t            result_tag,
	output lsq_types_pkg::data_t           result_data,
	output lsq_types_pkg::rob_idx_t        result_rob_idx,
	output logic                           lsq_full
);

	logic lq_full;
	logic sq_full;
	logic sq_empty;
	lsq_types_pkg::rob_idx_t sq_head_rob_idx;
	logic load_issue_valid;
	logic [$clog2(LQ_SIZE)-1:0] load_issue_index;
	logic fill_valid;
	logic [$clog2(LQ_SIZE)-1:0] fill_index;

	lsq_dispatch_if dispatch ();
	load_req_if #(.LQ_SIZE(LQ_SIZE)) load_req ();
	store_req_if store_req ();

	assign dispatch.valid = dispatch_valid;
	assign dispatch.is_store = dispatch_is_store;
	assign dispatch.base = dispatch_base;
	assign dispatch.offset = dispatch_offset;
	assign dispatch.offset_ready = dispatch_offset_ready;
	assign dispatch.store_data = dispatch_store_data;
	assign dispatch.store_data_ready = dispatch_store_data_ready;
	assign dispatch.rob_idx = dispatch_rob_idx;
	assign dispatch.dest_tag = dispatch_dest_tag;

	assign lsq_full = lq_full || sq_full;

	load_queue #(.LQ_SIZE(LQ_SIZE)) u_load_queue (
		.clock, .reset, .mispredict, .dispatch,
		.cdb_valid, .cdb_tag, .cdb_data, .rob_head,
		.sq_head_rob_idx, .sq_empty, .load_req,
		.fill_valid, .fill_index, .mem_data_in,
		.result_valid, .result_tag, .result_data, .result_rob_idx, .lq_full
	);

	store_queue #(.SQ_SIZE(SQ_SIZE)) u_store_queue (
		.clock, .reset, .mispredict, .dispatch,
		.cdb_valid, .cdb_tag, .cdb_data, .rob_head, .store_req,
		.sq_head_rob_idx, .sq_empty, .sq_full
	);

	mem_request_arbiter #(.LQ_SIZE(LQ_SIZE)) u_mem_request_arbiter (
		.clock, .reset, .mispredict, .load_req, .store_req,
		.mem_command, .mem_address, .mem_data, .mem_response,
		.load_issue_valid, .load_issue_index
	);

	mem_tag_table #(.LQ_SIZE(LQ_SIZE)) u_mem_tag_table (
		.clock, .reset, .mispredict, .load_issue_valid, .load_issue_index,
		.mem_response, .mem_tag, .fill_valid, .fill_index
	);

endmodule

`default_nettype wire

//--- lsq_if.sv
// Interfaces inside the load/store queue.
// Dispatch fans out to both queues, each queue offers one memory request
// to the arbiter and gets a grant pulse back when memory accepts it.

`timescale 1ns/1ps
`default_nettype none

interface lsq_dispatch_if;
	logic                    valid;
	logic                    is_store;
	lsq_types_pkg::data_t    base;
	lsq_types_pkg::data_t    offset;		// Tag in the low bits until ready
	logic                    offset_ready;
	lsq_types_pkg::data_t    store_data;	// Tag in the low bits until ready
	logic                    store_data_ready;
	lsq_types_pkg::rob_idx_t rob_idx;
	lsq_types_pkg::tag_t     dest_tag;

	modport receiver (input valid, is_store, base, offset, offset_ready,
		store_data, store_data_ready, rob_idx, dest_tag);
endinterface

interface load_req_if #(
	parameter int LQ_SIZE = 8
);
	logic                       valid;
	logic [$clog2(LQ_SIZE)-1:0] index;
	lsq_types_pkg::data_t       address;
	logic [LQ_SIZE-1:0]         grant;		// One-hot over load entries

	modport queue (output valid, index, address, input grant);
	modport arbiter (input valid, index, address, output grant);
endinterface

interface store_req_if;
	logic                 valid;
	lsq_types_pkg::data_t address;
	lsq_types_pkg::data_t data;
	logic                 grant;

	modport queue (output valid, address, data, input grant);
	modport arbiter (input valid, address, data, output grant);
endinterface

`default_nettype wire

//--- lsq_tb.sv
// Testbench for the load/store queue.
// Applies a table of loads and stores, plays the reorder buffer, checks
// results against a reference memory, then fills the load queue and flushes.

`timescale 1ns/1ps
`default_nettype none

module lsq_tb;

	localparam int LQ_SIZE = 8;
	localparam int SQ_SIZE = 8;
	localparam int ROWS = 14;
	localparam int LIMIT = (ROWS + LQ_SIZE) * 40 + 200;

	logic clock = 1'b0;
	logic reset;
	logic dispatch_valid, dispatch_is_store, dispatch_offset_ready, dispatch_store_data_ready;
	lsq_types_pkg::data_t dispatch_base, dispatch_offset, dispatch_store_data;
	lsq_types_pkg::rob_idx_t dispatch_rob_idx;
	lsq_types_pkg::tag_t dispatch_dest_tag;
	logic cdb_valid;
	lsq_types_pkg::tag_t cdb_tag;
	lsq_types_pkg::data_t cdb_data;
	lsq_types_pkg::rob_idx_t rob_head = '0;
	logic mispredict;
	logic stall;
	logic returns_pending;
	mem_bus_pkg::bus_command_e mem_command;
	lsq_types_pkg::data_t mem_address, mem_data, mem_data_in;
	mem_bus_pkg::mem_tag_t mem_response, mem_tag;
	logic result_valid;
	lsq_types_pkg::tag_t result_tag;
	lsq_types_pkg::data_t result_data;
	lsq_types_pkg::rob_idx_t result_rob_idx;
	logic lsq_full;

	// Stimulus table where the rob index of a row is its position
	logic row_store [ROWS];
	lsq_types_pkg::data_t row_base [ROWS];
	lsq_types_pkg::data_t row_offset [ROWS];
	logic [1:0] row_via [ROWS];	// 0 direct, 1 result bus same cycle, 2 one cycle later
	lsq_types_pkg::data_t row_sdata [ROWS];
	lsq_types_pkg::tag_t row_dest [ROWS];
	lsq_types_pkg::data_t row_expect [ROWS];
	logic result_seen [ROWS];

	logic [31:0] rob_done = '0;
	int store_order [$];
	int loads_left = 0;
	int stores_left = 0;
	logic flush_phase = 1'b0;
	int cycles = 0;
	logic prev_stalled = 1'b0;
	mem_bus_pkg::bus_command_e prev_command;
	lsq_types_pkg::data_t prev_address, prev_data;

	lsq #(.LQ_SIZE(LQ_SIZE), .SQ_SIZE(SQ_SIZE)) dut (.*);

	lsq_tb_mem #(.SEED(32'h988276f5)) u_mem (
		.clock, .stall, .mem_command, .mem_address, .mem_data,
		.mem_response, .mem_tag, .mem_data_in, .returns_pending
	);

	always #10 clock = ~clock;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge clock) begin
		cycles++;
		if (cycles >= LIMIT)
			fail_run($sformatf("ERROR: run did not finish within %0d cycles", LIMIT));
	end

	////////////////////
	// Output monitor
	////////////////////
	always @(posedge clock) begin
		int r;
		if (!reset) begin
			if (result_valid === 1'b1) begin
				r = int'(result_rob_idx);
				assert (!flush_phase && r < ROWS)
				else fail_run("ERROR: result appeared for a flushed or unknown load");
				if (r < ROWS) begin
					assert (!row_store[r] && !result_seen[r])
					else fail_run("ERROR: repeated result or result for a store");
					assert (result_tag == row_dest[r])
					else fail_run($sformatf("CHECK FAILED: result_tag got %h expected %h",
						result_tag, row_dest[r]));
					assert (result_data == row_expect[r])
					else fail_run($sformatf("CHECK FAILED: result_data got %h expected %h",
						result_data, row_expect[r]));
					result_seen[r] = 1'b1;
					rob_done[r] = 1'b1;
					loads_left--;
				end
			end
			if (mem_command == mem_bus_pkg::bus_store) begin
				assert (store_order.size() > 0)
				else fail_run("ERROR: store on the memory port with none outstanding");
				r = store_order[0];
				assert (rob_head == lsq_types_pkg::rob_idx_t'(r))
				else fail_run($sformatf("CHECK FAILED: rob_head got %h expected %h", rob_head, r));
				assert (mem_address == row_base[r] + row_offset[r])
				else fail_run($sformatf("CHECK FAILED: mem_address got %h expected %h",
					mem_address, row_base[r] + row_offset[r]));
				assert (mem_data == row_sdata[r])
				else fail_run($sformatf("CHECK FAILED: mem_data got %h expected %h",
					mem_data, row_sdata[r]));
				if (mem_response != '0) begin
					void'(store_order.pop_front());
					rob_done[r] = 1'b1;
					stores_left--;
				end
			end
			// Refused request must come back unchanged
			if (prev_stalled) begin
				assert (mem_command == prev_command)
				else fail_run($sformatf("CHECK FAILED: mem_command got %h expected %h",
					mem_command, prev_command));
				assert (mem_address == prev_address)
				else fail_run($sformatf("CHECK FAILED: mem_address got %h expected %h",
					mem_address, prev_address));
				assert (mem_data == prev_data)
				else fail_run($sformatf("CHECK FAILED: mem_data got %h expected %h",
					mem_data, prev_data));
			end
			prev_stalled = mem_command != mem_bus_pkg::bus_none && mem_response == '0 &&
				!mispredict;
			prev_command = mem_command;
			prev_address = mem_address;
			prev_data = mem_data;
		end
	end

	// Reorder buffer head moves past every finished instruction
	always @(posedge clock) begin
		#1;
		while (rob_done[rob_head])
			rob_head = rob_head + 5'd1;
	end

	task automatic add_row(input int r, input logic st, input int base, input int off,
			input logic [1:0] via, input lsq_types_pkg::data_t sdata, input int dest);
		row_store[r] = st;
		row_base[r] = lsq_types_pkg::data_t'(base);
		row_offset[r] = lsq_types_pkg::data_t'(off);
		row_via[r] = via;
		row_sdata[r] = sdata;
		row_dest[r] = lsq_types_pkg::tag_t'(dest);
		result_seen[r] = 1'b0;
	endtask

	// Reference memory with stores applied in program order
	task automatic build_expected();
		lsq_types_pkg::data_t ref_mem [64];
		lsq_types_pkg::data_t addr;
		for (int i = 0; i < 64; i++)
			ref_mem[i] = lsq_types_pkg::data_t'(i * 3 + 1);
		for (int r = 0; r < ROWS; r++) begin
			addr = row_base[r] + row_offset[r];
			row_expect[r] = ref_mem[addr[5:0]];
			if (row_store[r]) begin
				ref_mem[addr[5:0]] = row_sdata[r];
				store_order.push_back(r);
				stores_left++;
			end else begin
				loads_left++;
			end
		end
	endtask

	task automatic check_idle();
		assert (mem_command === mem_bus_pkg::bus_none)
		else fail_run($sformatf("CHECK FAILED: mem_command got %h expected 0", mem_command));
		assert (result_valid === 1'b0)
		else fail_run($sformatf("CHECK FAILED: result_valid got %h expected 0", result_valid));
		assert (lsq_full === 1'b0)
		else fail_run($sformatf("CHECK FAILED: lsq_full got %h expected 0", lsq_full));
	endtask

	task automatic drive_cdb(input int r);
		cdb_valid = 1'b1;
		cdb_tag = lsq_types_pkg::tag_t'(40 + r);	// Producer tag of the offset
		cdb_data = row_offset[r];
	endtask

	task automatic dispatch_row(input int r);
		while (lsq_full === 1'b1) begin
			@(posedge clock);
			#1;
		end
		dispatch_valid = 1'b1;
		dispatch_is_store = row_store[r];
		dispatch_base = row_base[r];
		dispatch_offset = row_via[r] == 2'd0 ? row_offset[r] : lsq_types_pkg::data_t'(40 + r);
		dispatch_offset_ready = row_via[r] == 2'd0;
		dispatch_store_data = row_sdata[r];
		dispatch_store_data_ready = 1'b1;
		dispatch_rob_idx = lsq_types_pkg::rob_idx_t'(r);
		dispatch_dest_tag = row_dest[r];
		if (row_via[r] == 2'd1)
			drive_cdb(r);
		@(posedge clock);
		#1;
		dispatch_valid = 1'b0;
		cdb_valid = 1'b0;
		if (row_via[r] == 2'd2) begin
			drive_cdb(r);
			@(posedge clock);
			#1;
			cdb_valid = 1'b0;
		end
	endtask

	initial begin
		reset = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_is_store = 1'b0;
		dispatch_base = '0;
		dispatch_offset = '0;
		dispatch_offset_ready = 1'b0;
		dispatch_store_data = '0;
		dispatch_store_data_ready = 1'b0;
		dispatch_rob_idx = '0;
		dispatch_dest_tag = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		mispredict = 1'b0;
		stall = 1'b0;

		add_row(0, 1'b0, 10, 2, 2'd0, '0, 1);
		add_row(1, 1'b0, 20, 5, 2'd1, '0, 2);
		add_row(2, 1'b1, 30, 0, 2'd0, 64'h1111, 0);
		add_row(3, 1'b0, 28, 2, 2'd2, '0, 3);	// Younger load to the store's address
		add_row(4, 1'b0, 7, 5, 2'd0, '0, 4);
		add_row(5, 1'b0, 7, 5, 2'd2, '0, 5);	// Same address with the offset from the result bus
		add_row(6, 1'b1, 40, 3, 2'd1, 64'hdead_beef, 0);
		add_row(7, 1'b0, 43, 0, 2'd0, '0, 6);
		add_row(8, 1'b0, 50, 1, 2'd0, '0, 7);
		add_row(9, 1'b1, 12, 0, 2'd2, 64'h2222_0000, 0);
		add_row(10, 1'b0, 6, 6, 2'd0, '0, 8);
		add_row(11, 1'b0, 60, 3, 2'd1, '0, 9);
		add_row(12, 1'b0, 1, 1, 2'd0, '0, 10);
		add_row(13, 1'b0, 33, 0, 2'd2, '0, 11);
		build_expected();

		repeat (16) begin
			@(posedge clock);
			#1;
			check_idle();
		end
		reset = 1'b0;
		@(posedge clock);
		#1;
		check_idle();

		for (int r = 0; r < ROWS; r++)
			dispatch_row(r);
		while (loads_left > 0 || stores_left > 0)
			@(posedge clock);
		#1;

		////////////////////
		// Fill the load queue while memory holds back its returns, then flush
		////////////////////
		stall = 1'b1;
		flush_phase = 1'b1;
		for (int i = 0; i < LQ_SIZE; i++) begin
			dispatch_valid = 1'b1;
			dispatch_is_store = 1'b0;
			dispatch_base = lsq_types_pkg::data_t'(i);
			dispatch_offset = '0;
			dispatch_offset_ready = 1'b1;
			dispatch_rob_idx = lsq_types_pkg::rob_idx_t'(ROWS + i);
			dispatch_dest_tag = lsq_types_pkg::tag_t'(20 + i);
			@(posedge clock);
			#1;
		end
		dispatch_valid = 1'b0;
		assert (lsq_full === 1'b1)
		else fail_run($sformatf("CHECK FAILED: lsq_full got %h expected 1", lsq_full));
		mispredict = 1'b1;
		@(posedge clock);
		#1;
		mispredict = 1'b0;
		assert (lsq_full === 1'b0)
		else fail_run($sformatf("CHECK FAILED: lsq_full got %h expected 0", lsq_full));
		stall = 1'b0;	// Data for the flushed tags comes back now
		do
			@(posedge clock);
		while (returns_pending === 1'b1);
		repeat (2) @(posedge clock);
		#1;
		check_idle();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- lsq_tb_mem.sv
// Data memory model for the load/store queue testbench.
// 64 words, accepts requests after random stalls and returns load data
// under its tag in a random order. Stores are written on acceptance.
// Load returns can be held back to leave loads in flight across a flush.

`timescale 1ns/1ps
`default_nettype none

module lsq_tb_mem #(
	parameter logic [31:0] SEED = 32'h988276f5
) (
	input  wire                            clock,
	input  wire                            stall,	// Hold back load returns while high
	input  wire mem_bus_pkg::bus_command_e mem_command,
	input  wire lsq_types_pkg::data_t      mem_address,
	input  wire lsq_types_pkg::data_t      mem_data,
	output mem_bus_pkg::mem_tag_t          mem_response,
	output mem_bus_pkg::mem_tag_t          mem_tag,
	output lsq_types_pkg::data_t           mem_data_in,
	output logic                           returns_pending
);

	lsq_types_pkg::data_t words [64];
	mem_bus_pkg::mem_tag_t pend_tag [$];	// Accepted loads not yet returned
	lsq_types_pkg::data_t pend_data [$];
	logic [31:0] state;
	logic accept_en;
	mem_bus_pkg::mem_tag_t offer_tag;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function logic tag_busy(input mem_bus_pkg::mem_tag_t t);
		foreach (pend_tag[i])
			if (pend_tag[i] == t)
				return 1'b1;
		return t == mem_tag;	// Tag on the return bus this cycle
	endfunction

	assign mem_response = (accept_en && mem_command != mem_bus_pkg::bus_none) ?
		offer_tag : '0;

	initial begin
		for (int i = 0; i < 64; i++)
			words[i] = lsq_types_pkg::data_t'(i * 3 + 1);
		state = SEED;
		accept_en = 1'b0;
		offer_tag = 4'd1;
		mem_tag = '0;
		mem_data_in = '0;
		returns_pending = 1'b0;
	end

	always @(posedge clock) begin
		int k;
		mem_bus_pkg::mem_tag_t t;
		if (mem_response != '0) begin
			if (mem_command == mem_bus_pkg::bus_store) begin
				words[mem_address[5:0]] = mem_data;
			end else begin
				pend_tag.push_back(mem_response);
				pend_data.push_back(words[mem_address[5:0]]);
			end
		end
		#1;
		state = lcg_next(state);
		accept_en = state[21:20] != 2'b00;	// Three cycles in four
		mem_tag = '0;
		mem_data_in = '0;
		if (pend_tag.size() > 0 && state[27] && !stall) begin
			k = int'(state[15:8]) % pend_tag.size();
			mem_tag = pend_tag[k];
			mem_data_in = pend_data[k];
			pend_tag.delete(k);
			pend_data.delete(k);
		end
		offer_tag = '0;
		for (int j = 0; j < 16; j++) begin
			t = state[3:0] + 4'(j);
			if (t != '0 && offer_tag == '0 && !tag_busy(t))
				offer_tag = t;
		end
		if (offer_tag == '0)
			accept_en = 1'b0;	// No free tag
		returns_pending = pend_tag.size() > 0;
	end

endmodule

`default_nettype wire

//--- lsq_types_pkg.sv
// Operand, register tag and reorder-buffer types shared by the load/store queue.
// Files refer to these by scoped names.

`default_nettype none

package lsq_types_pkg;

	localparam int DATA_WIDTH = 64;
	localparam int PRF_SIZE = 64;	// Physical registers
	localparam int ROB_SIZE = 32;	// Reorder-buffer entries

	// Data word or byte address
	typedef logic [DATA_WIDTH-1:0] data_t;

	// Physical register tag, as carried on the result bus
	typedef logic [$clog2(PRF_SIZE)-1:0] tag_t;

	// Reorder-buffer index, age is the distance from the ROB head
	typedef logic [$clog2(ROB_SIZE)-1:0] rob_idx_t;

endpackage

`default_nettype wire

//--- mem_bus_pkg.sv
// Data memory port definitions.
// Command encoding and the tag space for non-blocking loads.

`default_nettype none

package mem_bus_pkg;

	localparam int MEM_TAGS = 16;	// Tag zero means no transaction

	typedef logic [$clog2(MEM_TAGS)-1:0] mem_tag_t;

	typedef enum logic [1:0] {
		bus_none  = 2'd0,
		bus_load  = 2'd1,
		bus_store = 2'd2
	} bus_command_e;

endpackage

`default_nettype wire

//--- mem_request_arbiter.sv
// Memory port driver. A refused request is held and replayed before anything
// else, otherwise the committed store beats the load. Grants pulse back to the
// queue that owns the accepted request.

`timescale 1ns/1ps
`default_nettype none

module mem_request_arbiter #(
	parameter int LQ_SIZE = 8,
	localparam int IDX_W = $clog2(LQ_SIZE)
) (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            mispredict,
	load_req_if.arbiter                    load_req,
	store_req_if.arbiter                   store_req,
	output mem_bus_pkg::bus_command_e      mem_command,
	output lsq_types_pkg::data_t           mem_address,
	output lsq_types_pkg::data_t           mem_data,
	input  wire mem_bus_pkg::mem_tag_t     mem_response,
	output logic                           load_issue_valid,
	output logic [IDX_W-1:0]               load_issue_index
);

	logic hold_valid;
	mem_bus_pkg::bus_command_e hold_command;
	lsq_types_pkg::data_t hold_address;
	lsq_types_pkg::data_t hold_data;
	logic [IDX_W-1:0] hold_index;
	logic accepted;

	always_comb begin
		mem_command = mem_bus_pkg::bus_none;
		mem_address = '0;
		mem_data = '0;
		load_issue_index = load_req.index;
		if (hold_valid) begin
			mem_command = hold_command;	// Replay exactly what was refused
			mem_address = hold_address;
			mem_data = hold_data;
			load_issue_index = hold_index;
		end else if (store_req.valid) begin
			mem_command = mem_bus_pkg::bus_store;
			mem_address = store_req.address;
			mem_data = store_req.data;
		end else if (load_req.valid) begin
			mem_command = mem_bus_pkg::bus_load;
			mem_address = load_req.address;
		end
	end

	assign accepted = mem_command != mem_bus_pkg::bus_none && mem_response != '0;
	assign store_req.grant = accepted && mem_command == mem_bus_pkg::bus_store;
	assign load_issue_valid = accepted && mem_command == mem_bus_pkg::bus_load;
	assign load_req.grant = load_issue_valid ? LQ_SIZE'(1) << load_issue_index : '0;

	always_ff @(posedge clock) begin
		if (reset || mispredict)
			hold_valid <= 1'b0;
		else
			hold_valid <= mem_command != mem_bus_pkg::bus_none && !accepted;
	end

	// Request snapshot, frozen while a hold is pending
	always_ff @(posedge clock) begin
		if (!hold_valid) begin
			hold_command <= mem_command;
			hold_address <= mem_address;
			hold_data <= mem_data;
			hold_index <= load_issue_index;
		end
	end

endmodule

`default_nettype wire

//--- mem_tag_table.sv
// Outstanding load table indexed by memory tag.
// Returns a fill for the owning load entry when its tag comes back.

`timescale 1ns/1ps
`default_nettype none

module mem_tag_table #(
	parameter int LQ_SIZE = 8,
	localparam int IDX_W = $clog2(LQ_SIZE)
) (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            mispredict,
	input  wire                            load_issue_valid,
	input  wire [IDX_W-1:0]                load_issue_index,
	input  wire mem_bus_pkg::mem_tag_t     mem_response,
	input  wire mem_bus_pkg::mem_tag_t     mem_tag,
	output logic                           fill_valid,
	output logic [IDX_W-1:0]               fill_index
);

	logic [mem_bus_pkg::MEM_TAGS-1:0] tag_valid;
	logic [IDX_W-1:0] tag_index [mem_bus_pkg::MEM_TAGS];

	assign fill_valid = tag_valid[mem_tag];	// Tag zero is never written
	assign fill_index = tag_index[mem_tag];

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			tag_valid <= '0;	// Late returns of flushed loads are dropped
		end else begin
			if (fill_valid)
				tag_valid[mem_tag] <= 1'b0;
			if (load_issue_valid)
				tag_valid[mem_response] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (load_issue_valid)
			tag_index[mem_response] <= load_issue_index;
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the load/store queue testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module lsq_tb -f lsq.f -o lsq_sim
./obj_dir/lsq_sim

//--- store_queue.sv
// Store queue. A circular buffer in program order that captures address
// offset and store data from the result bus. Only the head store is offered
// to memory, and only once the reorder buffer head has reached it.

`timescale 1ns/1ps
`default_nettype none

module store_queue #(
	parameter int SQ_SIZE = 8,
	localparam int IDX_W = $clog2(SQ_SIZE)
) (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            mispredict,
	lsq_dispatch_if.receiver               dispatch,
	input  wire                            cdb_valid,
	input  wire lsq_types_pkg::tag_t       cdb_tag,
	input  wire lsq_types_pkg::data_t      cdb_data,
	input  wire lsq_types_pkg::rob_idx_t   rob_head,
	store_req_if.queue                     store_req,
	output lsq_types_pkg::rob_idx_t        sq_head_rob_idx,
	output logic                           sq_empty,
	output logic                           sq_full
);

	logic [IDX_W:0] head;	// Extra bit tells full from empty
	logic [IDX_W:0] tail;
	logic [IDX_W-1:0] head_idx;
	logic [IDX_W-1:0] tail_idx;

	logic [SQ_SIZE-1:0] offset_ready;
	logic [SQ_SIZE-1:0] data_ready;
	lsq_types_pkg::data_t base [SQ_SIZE];
	lsq_types_pkg::data_t offset [SQ_SIZE];
	lsq_types_pkg::data_t data [SQ_SIZE];
	lsq_types_pkg::rob_idx_t rob_idx [SQ_SIZE];

	logic dispatch_store;
	logic offset_hit;
	logic data_hit;

	assign head_idx = head[IDX_W-1:0];
	assign tail_idx = tail[IDX_W-1:0];
	assign sq_empty = head == tail;
	assign sq_full = head[IDX_W] != tail[IDX_W] && head_idx == tail_idx;
	assign sq_head_rob_idx = rob_idx[head_idx];

	assign dispatch_store = dispatch.valid && dispatch.is_store && !sq_full;
	assign offset_hit = !dispatch.offset_ready && cdb_valid &&
		cdb_tag == lsq_types_pkg::tag_t'(dispatch.offset);
	assign data_hit = !dispatch.store_data_ready && cdb_valid &&
		cdb_tag == lsq_types_pkg::tag_t'(dispatch.store_data);

	// Head store goes out at commit
	assign store_req.valid = !sq_empty && offset_ready[head_idx] &&
		data_ready[head_idx] && rob_idx[head_idx] == rob_head;
	assign store_req.address = base[head_idx] + offset[head_idx];
	assign store_req.data = data[head_idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
		end else begin
			if (store_req.grant)
				head <= head + 1'b1;
			if (mispredict)
				tail <= head + (IDX_W + 1)'(store_req.grant);	// Drop all uncommitted stores
			else if (dispatch_store)
				tail <= tail + 1'b1;
		end
	end

	////////////////////
	// Entry fill and operand capture
	////////////////////
	always_ff @(posedge clock) begin
		for (int i = 0; i < SQ_SIZE; i++) begin
			if (dispatch_store && tail_idx == IDX_W'(i)) begin
				base[i] <= dispatch.base;
				offset[i] <= offset_hit ? cdb_data : dispatch.offset;
				offset_ready[i] <= dispatch.offset_ready || offset_hit;
				data[i] <= data_hit ? cdb_data : dispatch.store_data;
				data_ready[i] <= dispatch.store_data_ready || data_hit;
				rob_idx[i] <= dispatch.rob_idx;
			end else begin
				if (!offset_ready[i] && cdb_valid &&
						cdb_tag == lsq_types_pkg::tag_t'(offset[i])) begin
					offset[i] <= cdb_data;
					offset_ready[i] <= 1'b1;
				end
				if (!data_ready[i] && cdb_valid &&
						cdb_tag == lsq_types_pkg::tag_t'(data[i])) begin
					data[i] <= cdb_data;
					data_ready[i] <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire
